// File: verilog.f
logic/mem_align_pkg.sv
logic/word_ram.sv
logic/align_fixer.sv
logic/access_port.sv
logic/mem_align_top.sv
tb/tb_mem_align.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the memory alignment testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_mem_align \
    -f verilog.f \
    -o tb_mem_align

output=$(./obj_dir/tb_mem_align)
echo "$output"

# Result is decided by the pass line alone
if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb/tb_mem_align.sv
// Testbench for the memory alignment subsystem
// Directed tests checked against a byte-array model of the data memory
`timescale 1ns/100ps
`default_nettype none

module tb_mem_align;

    localparam int CLK_HALF       = 2;      // 4 ns period
    localparam int RESET_CYCLES   = 3;
    localparam int TEST_WORDS     = 16;     // Words filled by the first test
    localparam int RANDOM_COUNT   = 100;
    localparam int TIMEOUT_CYCLES = 2000;   // About 160 accesses at 3 cycles plus idle gaps

    logic                    clk;
    logic                    reset;
    logic                    req_valid;
    mem_align_pkg::mem_req_t req;
    logic                    req_ready;
    logic                    rsp_valid;
    mem_align_pkg::mem_rsp_t rsp;

    logic [7:0]              model_mem [int];   // One entry per byte address
    mem_align_pkg::mem_req_t issued_q [$];      // Accepted requests of the stream test
    mem_align_pkg::mem_rsp_t exp_q [$];         // Their expected responses, same order
    integer                  seed;
    int                      errors;
    int                      checks;
    int                      cycle_count = 0;

    mem_align_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int size_bytes(mem_align_pkg::size_t size);
        case (size)
            mem_align_pkg::SIZE_BYTE: return 1;
            mem_align_pkg::SIZE_HALF: return 2;
            default:                  return 4;
        endcase
    endfunction

    // Natural alignment rule
    function automatic logic is_misaligned(mem_align_pkg::addr_t addr,
                                           mem_align_pkg::size_t size);
        return (addr % size_bytes(size)) != 0;
    endfunction

    // Response the model predicts, taken before a store changes it
    function automatic mem_align_pkg::mem_rsp_t model_response(mem_align_pkg::mem_req_t r);
        mem_align_pkg::mem_rsp_t e;
        e.rdata = '0;                                   // Zero-extended, zero for stores
        e.error = is_misaligned(r.addr, r.size);
        if (!r.write && !e.error) begin
            for (int i = 0; i < size_bytes(r.size); i++) begin
                e.rdata[8*i +: 8] = model_mem[int'(r.addr) + i];   // Little-endian
            end
        end
        return e;
    endfunction

    function automatic void model_update(mem_align_pkg::mem_req_t r);
        if (r.write && !is_misaligned(r.addr, r.size)) begin
            for (int i = 0; i < size_bytes(r.size); i++) begin
                model_mem[int'(r.addr) + i] = r.wdata[8*i +: 8];
            end
        end
    endfunction

    task automatic compare_rsp(input mem_align_pkg::mem_req_t r,
                               input mem_align_pkg::mem_rsp_t got,
                               input mem_align_pkg::mem_rsp_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s of %0d bytes at %h gave rdata %h error %b, expected %h %b",
                     $time, r.write ? "write" : "read", size_bytes(r.size), r.addr,
                     got.rdata, got.error, exp.rdata, exp.error);
            errors++;
        end
    endtask

    // One request, waits for its response and counts cycles from the handshake edge
    task automatic do_access(input mem_align_pkg::mem_req_t r,
                             output mem_align_pkg::mem_rsp_t got, output int latency);
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);       // Handshake edge
        #1;
        req_valid = 1'b0;
        req       = '0;       // Port must hold its own copy
        latency   = 1;
        @(negedge clk);
        while (!rsp_valid) begin
            @(negedge clk);
            latency++;
        end
        got = rsp;
        @(posedge clk);
        #1;
    endtask

    task automatic run_check(input mem_align_pkg::addr_t addr, input mem_align_pkg::data_t wdata,
                             input mem_align_pkg::size_t size, input logic write);
        mem_align_pkg::mem_req_t r;
        mem_align_pkg::mem_rsp_t exp;
        mem_align_pkg::mem_rsp_t got;
        int                      exp_lat;
        int                      lat;
        r.addr  = addr;
        r.wdata = wdata;
        r.size  = size;
        r.write = write;
        exp     = model_response(r);
        exp_lat = (write && !exp.error && size != mem_align_pkg::SIZE_WORD) ? 3 : 2;
        model_update(r);
        do_access(r, got, lat);
        compare_rsp(r, got, exp);
        checks++;
        if (lat != exp_lat) begin
            $display("ERR %0t: response %0d cycles after accept at %h, expected %0d",
                     $time, lat, addr, exp_lat);
            errors++;
        end
    endtask

    task automatic make_random_request(output mem_align_pkg::mem_req_t r);
        logic [31:0] rnd;
        rnd         = $random(seed);
        r.addr      = '0;
        r.addr[5:0] = rnd[5:0];                        // Stays inside the filled words
        case (rnd[9:8])
            2'd0:    r.size = mem_align_pkg::SIZE_BYTE;
            2'd1:    r.size = mem_align_pkg::SIZE_HALF;
            default: r.size = mem_align_pkg::SIZE_WORD;
        endcase
        r.write     = rnd[12];
        r.wdata     = $random(seed);
    endtask

    // req_ready low for one cycle after reset, then high
    task automatic check_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;
        @(negedge clk);
        checks++;
        if (req_ready !== 1'b0 || rsp_valid !== 1'b0) begin
            $display("ERR %0t: req_ready %b rsp_valid %b right after reset, expected 0 0",
                     $time, req_ready, rsp_valid);
            errors++;
        end
        @(negedge clk);
        checks++;
        if (req_ready !== 1'b1) begin
            $display("ERR %0t: req_ready still low two cycles after reset", $time);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_word_access();
        for (int w = 0; w < TEST_WORDS; w++) begin
            run_check(4 * w, $random(seed), mem_align_pkg::SIZE_WORD, 1'b1);
        end
        for (int w = 0; w < TEST_WORDS; w++) begin
            run_check(4 * w, '0, mem_align_pkg::SIZE_WORD, 1'b0);
        end
    endtask

    // Store data carries random upper bytes, which must not reach memory
    task automatic test_subword_writes();
        for (int i = 0; i < 4; i++) begin
            run_check(4 + i, $random(seed), mem_align_pkg::SIZE_BYTE, 1'b1);
            run_check(4, '0, mem_align_pkg::SIZE_WORD, 1'b0);     // Only lane i changed
        end
        run_check(8, $random(seed), mem_align_pkg::SIZE_HALF, 1'b1);   // Keeps bytes 2 and 3
        run_check(8, '0, mem_align_pkg::SIZE_WORD, 1'b0);
        run_check(10, $random(seed), mem_align_pkg::SIZE_HALF, 1'b1);
        run_check(8, '0, mem_align_pkg::SIZE_WORD, 1'b0);
        run_check(0, '0, mem_align_pkg::SIZE_WORD, 1'b0);         // Neighbours untouched
        run_check(12, '0, mem_align_pkg::SIZE_WORD, 1'b0);
    endtask

    task automatic test_subword_reads();
        for (int w = 3; w < 5; w++) begin
            for (int off = 0; off < 4; off++) begin
                run_check(4 * w + off, '0, mem_align_pkg::SIZE_BYTE, 1'b0);
            end
            run_check(4 * w, '0, mem_align_pkg::SIZE_HALF, 1'b0);
            run_check(4 * w + 2, '0, mem_align_pkg::SIZE_HALF, 1'b0);
        end
    endtask

    task automatic test_misaligned();
        run_check(21, '0, mem_align_pkg::SIZE_HALF, 1'b0);
        run_check(23, '0, mem_align_pkg::SIZE_HALF, 1'b0);
        run_check(21, 32'hdead_beef, mem_align_pkg::SIZE_HALF, 1'b1);
        for (int off = 1; off < 4; off++) begin
            run_check(20 + off, '0, mem_align_pkg::SIZE_WORD, 1'b0);
            run_check(24 + off, $random(seed), mem_align_pkg::SIZE_WORD, 1'b1);
        end
        run_check(20, '0, mem_align_pkg::SIZE_WORD, 1'b0);    // Both words unchanged
        run_check(24, '0, mem_align_pkg::SIZE_WORD, 1'b0);
    endtask

    // req_valid held through back-pressure, next request offered right after accept
    task automatic test_stream_random();
        mem_align_pkg::mem_req_t r;
        mem_align_pkg::mem_rsp_t cur_exp;
        int                      n_sent;
        int                      n_recv;
        int                      stalls;
        logic                    handshake;
        n_sent = 0;
        n_recv = 0;
        stalls = 0;
        issued_q.delete();
        exp_q.delete();
        make_random_request(r);
        cur_exp = model_response(r);
        model_update(r);
        req_valid = 1'b1;
        req       = r;
        while (n_recv < RANDOM_COUNT) begin
            @(negedge clk);
            handshake = req_valid && req_ready;
            if (req_valid && !req_ready) begin
                stalls++;
            end
            if (rsp_valid) begin
                checks++;
                if (exp_q.size() == 0) begin
                    $display("Response at %0t arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    compare_rsp(issued_q.pop_front(), rsp, exp_q.pop_front());
                end
                n_recv++;
            end
            @(posedge clk);
            #1;
            if (handshake) begin
                issued_q.push_back(req);
                exp_q.push_back(cur_exp);
                n_sent++;
                if (n_sent < RANDOM_COUNT) begin
                    make_random_request(r);
                    cur_exp = model_response(r);   // Model follows accept order
                    model_update(r);
                    req     = r;
                end else begin
                    req_valid = 1'b0;
                    req       = '0;
                end
            end
        end
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (rsp_valid) begin
                $display("Extra response at %0t after the last request", $time);
                errors++;
            end
        end
        checks++;
        if (n_sent != RANDOM_COUNT || exp_q.size() != 0 || stalls == 0) begin
            $display("Stream mismatch: %0d sent, %0d answered, %0d pending, %0d stalls",
                     n_sent, n_recv, exp_q.size(), stalls);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed      = 99;
        errors    = 0;
        checks    = 0;
        reset     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        check_reset();
        test_word_access();
        test_subword_writes();
        test_subword_reads();
        test_misaligned();
        test_stream_random();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/mem_align_top.sv
// Memory alignment subsystem top
// Access port, alignment fixer and word RAM
`timescale 1ns/100ps
`default_nettype none

module mem_align_top (
    input  wire                        clk,
    input  wire                        reset,
    // Request channel
    input  wire                        req_valid,
    input  wire mem_align_pkg::mem_req_t req,
    output logic                       req_ready,
    // Response channel
    output logic                       rsp_valid,
    output mem_align_pkg::mem_rsp_t    rsp
);

    // Port to fixer
    logic                     acc_valid;
    mem_align_pkg::mem_req_t  acc;
    logic                     acc_done;
    mem_align_pkg::data_t     acc_rdata;
    logic                     acc_error;

    // Fixer to RAM
    mem_align_pkg::ram_idx_t  ram_idx;
    mem_align_pkg::data_t     ram_rdata;
    logic                     ram_we;
    mem_align_pkg::ram_wr_t   ram_wr;

    access_port u_access_port (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .acc_valid (acc_valid),
        .acc       (acc),
        .acc_done  (acc_done),
        .acc_rdata (acc_rdata),
        .acc_error (acc_error),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    align_fixer u_align_fixer (
        .clk       (clk),
        .reset     (reset),
        .acc_valid (acc_valid),
        .acc       (acc),
        .acc_done  (acc_done),
        .acc_rdata (acc_rdata),
        .acc_error (acc_error),
        .ram_idx   (ram_idx),
        .ram_rdata (ram_rdata),
        .ram_we    (ram_we),
        .ram_wr    (ram_wr)
    );

    word_ram u_word_ram (
        .clk       (clk),
        .ram_idx   (ram_idx),
        .ram_rdata (ram_rdata),
        .ram_we    (ram_we),
        .ram_wr    (ram_wr)
    );

endmodule

`default_nettype wire

// File: logic/access_port.sv
// CPU-side access port
// Holds one request, presents it to the alignment fixer, registers the response
`timescale 1ns/100ps
`default_nettype none

module access_port (
    input  wire                      clk,
    input  wire                      reset,
    // Request channel from the CPU
    input  wire                      req_valid,
    input  wire mem_align_pkg::mem_req_t req,
    output logic                     req_ready,
    // Held access towards the fixer
    output logic                     acc_valid,
    output mem_align_pkg::mem_req_t  acc,
    input  wire                      acc_done,
    input  wire mem_align_pkg::data_t acc_rdata,
    input  wire                      acc_error,
    // Response channel without back-pressure
    output logic                     rsp_valid,
    output mem_align_pkg::mem_rsp_t  rsp
);

    typedef enum logic [1:0] {
        PORT_IDLE,     // Waiting for a request
        PORT_BUSY,     // Fixer working on the held request
        PORT_REPLY     // Response cycle that may accept again
    } port_state_t;

    port_state_t state;
    port_state_t state_next;

    logic ready_en;                     // Keeps req_ready low one cycle after reset
    logic accept;                       // Request handshake this cycle
    logic finish;                       // Fixer completes the held access

    mem_align_pkg::mem_req_t req_q;     // Holding register
    mem_align_pkg::mem_rsp_t rsp_q;     // Registered response

    // Ready in idle and in the reply cycle
    assign req_ready = ready_en && (state == PORT_IDLE || state == PORT_REPLY);
    assign accept    = req_valid && req_ready;
    assign finish    = (state == PORT_BUSY) && acc_done;

    assign acc_valid = (state == PORT_BUSY);   // Stable until acc_done
    assign acc       = req_q;
    assign rsp_valid = (state == PORT_REPLY);  // One-cycle pulse
    assign rsp       = rsp_q;

    // Sequencing
    always_comb begin
        state_next = state;
        case (state)
            PORT_IDLE: begin
                if (accept) begin
                    state_next = PORT_BUSY;
                end
            end
            PORT_BUSY: begin
                if (acc_done) begin
                    state_next = PORT_REPLY;   // Response goes out next cycle
                end
            end
            PORT_REPLY: begin
                // Back-to-back request accepted alongside the response
                state_next = accept ? PORT_BUSY : PORT_IDLE;
            end
            default: begin
                state_next = PORT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= PORT_IDLE;
            ready_en <= 1'b0;
        end else begin
            state    <= state_next;
            ready_en <= 1'b1;
        end
    end

    // Request capture on the handshake edge
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // Response capture on the done edge
    always_ff @(posedge clk) begin
        if (finish) begin
            rsp_q.rdata <= acc_rdata;   // Fixer returns zero for stores and errors
            rsp_q.error <= acc_error;
        end
    end

endmodule

`default_nettype wire

// File: logic/align_fixer.sv
// Alignment fixer
// Checks natural alignment, extracts sub-word loads, merges sub-word stores into the word
`timescale 1ns/100ps
`default_nettype none

module align_fixer (
    input  wire                        clk,
    input  wire                        reset,
    // Access from the port
    input  wire                        acc_valid,
    input  wire mem_align_pkg::mem_req_t acc,
    output logic                       acc_done,
    output mem_align_pkg::data_t       acc_rdata,
    output logic                       acc_error,
    // Word RAM
    output mem_align_pkg::ram_idx_t    ram_idx,
    input  wire mem_align_pkg::data_t  ram_rdata,
    output logic                       ram_we,
    output mem_align_pkg::ram_wr_t     ram_wr
);

    localparam int LANES = mem_align_pkg::BYTES_PER_WORD;

    typedef enum logic {
        FIX_MERGE,     // Idle or first cycle of an access
        FIX_COMMIT     // Writing back the merged word
    } fix_state_t;

    fix_state_t state;
    fix_state_t state_next;

    mem_align_pkg::offset_t offset;            // Byte lane of the address
    mem_align_pkg::offset_t align_mask;        // Offset bits that must be zero
    logic [LANES-1:0]       size_lanes;        // Lanes of the size at offset zero
    logic [LANES-1:0]       wr_lanes;          // Lanes touched in the word
    mem_align_pkg::data_t   size_bits;
    mem_align_pkg::data_t   wr_bits;
    mem_align_pkg::data_t   shifted_wdata;
    mem_align_pkg::data_t   merged;            // Old bytes with the new ones inserted
    mem_align_pkg::data_t   merge_q;
    logic                   misaligned;
    logic                   sub_word;

    assign offset  = acc.addr[mem_align_pkg::OFFSET_W-1:0];
    assign ram_idx = acc.addr[mem_align_pkg::RAM_IDX_W+mem_align_pkg::OFFSET_W-1:
                              mem_align_pkg::OFFSET_W];   // Word part of the address

    // Size decode
    always_comb begin
        case (acc.size)
            mem_align_pkg::SIZE_BYTE: begin
                size_lanes = 4'b0001;
                align_mask = 2'b00;    // Any offset
            end
            mem_align_pkg::SIZE_HALF: begin
                size_lanes = 4'b0011;
                align_mask = 2'b01;    // Even offsets only
            end
            default: begin
                size_lanes = 4'b1111;  // Word, also the unused code
                align_mask = 2'b11;
            end
        endcase
    end

    assign misaligned = |(offset & align_mask);
    assign sub_word   = ~&size_lanes;
    assign wr_lanes   = size_lanes << offset;
    assign acc_error  = misaligned;

    // Lane masks to bit masks
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            size_bits[8*i +: 8] = {8{size_lanes[i]}};
            wr_bits[8*i +: 8]   = {8{wr_lanes[i]}};
        end
    end

    // Load path, shift down and zero-extend
    always_comb begin
        if (acc.write || misaligned) begin
            acc_rdata = '0;
        end else begin
            acc_rdata = (ram_rdata >> {offset, 3'b000}) & size_bits;
        end
    end

    // Store path, also merges at offset zero to keep the upper bytes
    assign shifted_wdata = (acc.wdata & size_bits) << {offset, 3'b000};
    assign merged        = (ram_rdata & ~wr_bits) | shifted_wdata;

    always_comb begin
        state_next  = state;
        acc_done    = 1'b0;
        ram_we      = 1'b0;
        ram_wr.idx  = ram_idx;
        ram_wr.data = acc.wdata;               // Full-word store by default
        case (state)
            FIX_MERGE: begin
                if (acc_valid) begin
                    if (acc.write && !misaligned && sub_word) begin
                        state_next = FIX_COMMIT;     // Merged word held one cycle
                    end else begin
                        acc_done = 1'b1;             // Load, error or word store
                        ram_we   = acc.write && !misaligned;
                    end
                end
            end
            FIX_COMMIT: begin
                acc_done    = 1'b1;
                ram_we      = 1'b1;
                ram_wr.data = merge_q;
                state_next  = FIX_MERGE;
            end
            default: begin
                state_next = FIX_MERGE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= FIX_MERGE;
        end else begin
            state <= state_next;
        end
    end

    // Merge capture while waiting to commit
    always_ff @(posedge clk) begin
        if (state == FIX_MERGE) begin
            merge_q <= merged;
        end
    end

endmodule

`default_nettype wire

// File: logic/word_ram.sv
// Word RAM
// Aligned word storage, combinational read and write on the clock edge
`timescale 1ns/100ps
`default_nettype none

module word_ram (
    input  wire                         clk,
    input  wire mem_align_pkg::ram_idx_t ram_idx,
    output mem_align_pkg::data_t        ram_rdata,
    input  wire                         ram_we,
    input  wire mem_align_pkg::ram_wr_t ram_wr
);

    // Storage, contents undefined until written
    mem_align_pkg::data_t mem [mem_align_pkg::RAM_WORDS];

    // Read follows the index in the same cycle
    assign ram_rdata = mem[ram_idx];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_wr.idx] <= ram_wr.data;   // Whole word, merging done upstream
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_align_pkg.sv
// Memory alignment package
// Widths, size codes and the request, response and RAM write records
`default_nettype none

package mem_align_pkg;

    // Bus widths
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_WORD = DATA_W / 8;
    localparam int OFFSET_W       = 2;    // Byte offset inside a word

    // Data memory geometry
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = 8;

    typedef logic [ADDR_W-1:0]    addr_t;     // Byte address
    typedef logic [DATA_W-1:0]    data_t;     // One memory word
    typedef logic [OFFSET_W-1:0]  offset_t;   // Byte lane of an address
    typedef logic [RAM_IDX_W-1:0] ram_idx_t;  // Word index into the RAM

    // Access size, 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // CPU request, 67 bits
    typedef struct packed {
        addr_t addr;
        data_t wdata;   // Store data, low bytes used for sub-word sizes
        size_t size;
        logic  write;
    } mem_req_t;

    // CPU response, 33 bits
    typedef struct packed {
        data_t rdata;   // Zero-extended load data, zero for stores
        logic  error;   // Misaligned, memory untouched
    } mem_rsp_t;

    // RAM write, 40 bits
    typedef struct packed {
        ram_idx_t idx;
        data_t    data;
    } ram_wr_t;

endpackage

`default_nettype wire
